/* hdl/clk_cfg_pkg.sv */
// Link configuration types for the clocking controller
// Data rate, signaling and power mode encodings, rail voltage type, PLL constants

package clk_cfg_pkg;

    typedef enum logic [1:0] {
        RATE_32G  = 2'd0,
        RATE_64G  = 2'd1,
        RATE_128G = 2'd2
    } data_rate_t;

    typedef enum logic {
        SIG_NRZ  = 1'b0,
        SIG_PAM4 = 1'b1
    } signaling_mode_t;

    typedef enum logic [1:0] {
        PM_FULL  = 2'd0,
        PM_LOW   = 2'd1,
        PM_SLEEP = 2'd2
    } power_mode_t;

    typedef struct packed {
        data_rate_t      rate;
        signaling_mode_t signaling;
        power_mode_t     power_mode;
    } clk_cfg_t;

    typedef logic [11:0] vdd_mv_t;  // One rail in millivolts

    // Power-on configuration
    localparam clk_cfg_t CFG_DEFAULT = '{rate: RATE_128G, signaling: SIG_PAM4,
                                         power_mode: PM_FULL};

    localparam vdd_mv_t THERMAL_STEP_MV = 12'd50;

    // High-speed PLL multipliers against the 100 MHz reference
    localparam logic [15:0] MULT_128G_PAM4 = 16'd640;
    localparam logic [15:0] MULT_128G_NRZ  = 16'd1280;
    localparam logic [15:0] MULT_64G       = 16'd320;
    localparam logic [15:0] MULT_32G       = 16'd160;

endpackage

/* hdl/clk_status_pkg.sv */
// Controller status types
// Sequencer state encoding, rail voltage set and the 16-bit status word

package clk_status_pkg;

    import clk_cfg_pkg::*;

    typedef enum logic [3:0] {
        ST_RESET          = 4'd0,
        ST_POWER_UP       = 4'd1,
        ST_VOLTAGE_SCALE  = 4'd2,
        ST_PLL_CONFIG     = 4'd3,
        ST_LOCK_WAIT      = 4'd4,
        ST_CLOCK_ENABLE   = 4'd5,
        ST_ACTIVE         = 4'd6,
        ST_POWER_SAVE     = 4'd7,
        ST_THERMAL_LIMIT  = 4'd8,
        ST_ERROR_RECOVERY = 4'd9
    } seq_state_t;

    typedef struct packed {
        vdd_mv_t core;
        vdd_mv_t phy;
        vdd_mv_t pll;
    } vdd_set_t;

    typedef struct packed {
        seq_state_t state;             // [15:12]
        clk_cfg_t   cfg;               // [11:7]
        logic       pll_locked_both;
        logic       settling;
        logic       clocks_gated;
        logic       thermal_throttle;
        logic       domains_acked;
        logic       rails_ready;
        logic       reserved;          // Always zero
    } clk_status_t;

endpackage

/* hdl/clk_cfg_intake.sv */
// Configuration request intake
// Valid/ready acceptance and the active configuration register

`timescale 1ns/1ns

module clk_cfg_intake
    import clk_cfg_pkg::*;
(
    input  logic     ref_clk,
    input  logic     por_rst_n,
    input  logic     cfg_valid,
    input  clk_cfg_t cfg,
    output logic     cfg_ready,
    input  logic     seq_idle,
    output clk_cfg_t active_cfg
);

    logic cfg_accept;

    // Requests only land between sequences
    assign cfg_ready  = seq_idle;
    assign cfg_accept = cfg_valid && cfg_ready;

    always_ff @(posedge ref_clk or negedge por_rst_n) begin
        if (!por_rst_n) begin
            active_cfg <= CFG_DEFAULT;
        end else if (cfg_accept) begin
            active_cfg <= cfg;
        end
    end

    // Requester holds the word while stalled
    a_cfg_stable: assert property (
        @(posedge ref_clk) disable iff (!por_rst_n)
        (cfg_valid && !cfg_ready) |=> (!cfg_valid || $stable(cfg))
    ) else $error("cfg changed under back-pressure");

endmodule

/* hdl/clk_power_sequencer.sv */
// Bring-up and power-state FSM
// Power-domain control, PLL multiplier table, lock timer with timeout

`timescale 1ns/1ns

module clk_power_sequencer
    import clk_cfg_pkg::*;
    import clk_status_pkg::*;
#(
    parameter int NUM_POWER_DOMAINS   = 4,
    parameter int LOCK_TIMEOUT_CYCLES = 100000
) (
    input  logic                         ref_clk,
    input  logic                         por_rst_n,
    input  logic                         clocking_enable,
    input  logic                         thermal_throttle,
    input  clk_cfg_t                     active_cfg,
    input  logic [NUM_POWER_DOMAINS-1:0] domain_ack,
    output logic [NUM_POWER_DOMAINS-1:0] domain_enable,
    output logic [NUM_POWER_DOMAINS-1:0] domain_isolate,
    input  logic [2:0]                   rail_ready,
    input  logic                         settling,
    output logic                         scale_start,
    output logic                         thermal_step,
    input  logic                         pll_main_locked,
    input  logic                         pll_hs_locked,
    output logic                         pll_enable,
    output logic [15:0]                  pll_hs_mult,
    output logic [31:0]                  pll_lock_cycles,
    output logic                         seq_idle,
    output logic                         seq_active,
    output seq_state_t                   state,
    output logic                         all_clocks_stable
);

    seq_state_t  state_d;
    logic [31:0] lock_cnt;
    logic        both_locked;

    function automatic logic [15:0] hs_mult(clk_cfg_t c);
        case (c.rate)
            RATE_128G: return (c.signaling == SIG_PAM4) ? MULT_128G_PAM4 : MULT_128G_NRZ;
            RATE_64G:  return MULT_64G;
            default:   return MULT_32G;
        endcase
    endfunction

    assign both_locked = pll_main_locked && pll_hs_locked;
    assign seq_active  = (state == ST_ACTIVE);
    assign seq_idle    = state inside {ST_RESET, ST_ACTIVE, ST_POWER_SAVE, ST_THERMAL_LIMIT};

    always_comb begin
        state_d = state;
        case (state)
            ST_RESET:          if (clocking_enable) state_d = ST_POWER_UP;
            ST_POWER_UP:       if (&domain_ack) state_d = ST_VOLTAGE_SCALE;
            ST_VOLTAGE_SCALE: begin
                // First cycle is skipped since settling rises one edge after the pulse
                if (!scale_start && !settling && &rail_ready) state_d = ST_PLL_CONFIG;
            end
            ST_PLL_CONFIG:     state_d = ST_LOCK_WAIT;
            ST_LOCK_WAIT: begin
                if (both_locked) begin
                    state_d = ST_CLOCK_ENABLE;
                end else if (lock_cnt > 32'(LOCK_TIMEOUT_CYCLES)) begin
                    state_d = ST_ERROR_RECOVERY;
                end
            end
            ST_CLOCK_ENABLE:   state_d = ST_ACTIVE;
            ST_ACTIVE: begin
                if (thermal_throttle) begin
                    state_d = ST_THERMAL_LIMIT;
                end else if (active_cfg.power_mode == PM_LOW) begin
                    state_d = ST_POWER_SAVE;
                end else if (active_cfg.power_mode == PM_SLEEP) begin
                    state_d = ST_POWER_UP;  // Full re-bring-up
                end
            end
            ST_POWER_SAVE: begin
                if (active_cfg.power_mode == PM_FULL) begin
                    state_d = ST_ACTIVE;
                end else if (thermal_throttle) begin
                    state_d = ST_THERMAL_LIMIT;
                end
            end
            ST_THERMAL_LIMIT:  if (!thermal_throttle) state_d = ST_ACTIVE;
            default:           state_d = ST_RESET;
        endcase
    end

    always_ff @(posedge ref_clk or negedge por_rst_n) begin
        if (!por_rst_n) begin
            state             <= ST_RESET;
            scale_start       <= 1'b0;
            thermal_step      <= 1'b0;
            all_clocks_stable <= 1'b0;
        end else begin
            state             <= state_d;
            scale_start       <= (state_d == ST_VOLTAGE_SCALE) && (state != ST_VOLTAGE_SCALE);
            thermal_step      <= (state_d == ST_THERMAL_LIMIT) && (state != ST_THERMAL_LIMIT);
            all_clocks_stable <= both_locked && (state_d == ST_ACTIVE);
        end
    end

    always_ff @(posedge ref_clk or negedge por_rst_n) begin
        if (!por_rst_n) begin
            domain_enable  <= '0;
            domain_isolate <= '1;  // Isolated out of reset
        end else if (state == ST_POWER_UP) begin
            domain_enable  <= '1;
            domain_isolate <= '0;
        end else if (state == ST_RESET) begin
            domain_enable  <= '0;
            domain_isolate <= '1;
        end
    end

    always_ff @(posedge ref_clk or negedge por_rst_n) begin
        if (!por_rst_n) begin
            pll_enable      <= 1'b0;
            pll_hs_mult     <= MULT_128G_PAM4;
            pll_lock_cycles <= '0;
            lock_cnt        <= '0;
        end else begin
            case (state)
                ST_PLL_CONFIG: begin
                    pll_enable  <= 1'b1;
                    pll_hs_mult <= hs_mult(active_cfg);
                    lock_cnt    <= '0;
                end
                ST_LOCK_WAIT: begin
                    lock_cnt <= lock_cnt + 32'd1;
                    if (both_locked) pll_lock_cycles <= lock_cnt;  // Lock latency
                end
                ST_RESET, ST_ERROR_RECOVERY: begin
                    pll_enable <= 1'b0;
                    lock_cnt   <= '0;
                end
                default: ;
            endcase
        end
    end

    // A domain is never powered and clamped at once
    a_domain_exclusive: assert property (
        @(posedge ref_clk) disable iff (!por_rst_n)
        (domain_enable & domain_isolate) == '0
    ) else $error("domain enabled while isolated");

endmodule

/* hdl/vdd_scaler.sv */
// Rail voltage scaler
// Target lookup, settle timer and thermal step-down

`timescale 1ns/1ns

module vdd_scaler
    import clk_cfg_pkg::*;
    import clk_status_pkg::*;
#(
    parameter int SETTLE_CYCLES = 1000
) (
    input  logic     ref_clk,
    input  logic     por_rst_n,
    input  clk_cfg_t active_cfg,
    input  logic     scale_start,
    input  logic     thermal_step,
    output logic     settling,
    output vdd_set_t vdd
);

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    vdd_set_t         target;
    logic [CNT_W-1:0] settle_cnt;

    function automatic vdd_set_t lookup(clk_cfg_t c);
        if (c.rate == RATE_128G && c.power_mode == PM_FULL) begin
            return '{core: 12'd1000, phy: 12'd1200, pll: 12'd1300};
        end else if (c.rate == RATE_128G && c.power_mode == PM_LOW) begin
            return '{core: 12'd950, phy: 12'd1100, pll: 12'd1200};
        end else if (c.rate == RATE_64G && c.power_mode == PM_FULL) begin
            return '{core: 12'd950, phy: 12'd1100, pll: 12'd1200};
        end else if (c.rate == RATE_32G && c.power_mode == PM_FULL) begin
            return '{core: 12'd900, phy: 12'd1000, pll: 12'd1100};
        end
        return '{core: 12'd850, phy: 12'd950, pll: 12'd1000};  // Reduced-power fallback
    endfunction

    function automatic vdd_mv_t step_down(vdd_mv_t v);
        return (v > THERMAL_STEP_MV) ? v - THERMAL_STEP_MV : '0;
    endfunction

    // Setpoints for the next settle
    always_ff @(posedge ref_clk) begin
        if (scale_start) begin
            target <= lookup(active_cfg);
        end else if (thermal_step) begin
            target <= '{core: step_down(target.core), phy: step_down(target.phy),
                        pll: step_down(target.pll)};
        end
    end

    always_ff @(posedge ref_clk or negedge por_rst_n) begin
        if (!por_rst_n) begin
            settling   <= 1'b0;
            settle_cnt <= '0;
            vdd        <= '0;
        end else if (scale_start || thermal_step) begin
            settling   <= 1'b1;
            settle_cnt <= '0;
        end else if (settling) begin
            settle_cnt <= settle_cnt + 1'b1;
            if (settle_cnt == CNT_W'(SETTLE_CYCLES - 1)) begin
                settling <= 1'b0;
                vdd      <= target;  // Regulators follow the new setpoint
            end
        end
    end

    // Sequencer never restarts a scale mid-settle
    a_no_restart: assert property (
        @(posedge ref_clk) disable iff (!por_rst_n)
        scale_start |-> !settling
    ) else $error("scale_start while settling");

endmodule

/* hdl/clk_gate_monitor.sv */
// Idle monitor and status
// Idle counter, registered clock gates and status word assembly

`timescale 1ns/1ns

module clk_gate_monitor
    import clk_cfg_pkg::*;
    import clk_status_pkg::*;
#(
    parameter int IDLE_THRESHOLD    = 100,
    parameter int NUM_POWER_DOMAINS = 4
) (
    input  logic                         ref_clk,
    input  logic                         por_rst_n,
    input  logic                         protocol_active,
    input  logic                         phy_active,
    input  power_mode_t                  power_mode,
    input  logic                         seq_active,
    input  seq_state_t                   state,
    input  clk_cfg_t                     active_cfg,
    input  logic                         pll_main_locked,
    input  logic                         pll_hs_locked,
    input  logic                         settling,
    input  logic                         thermal_throttle,
    input  logic [NUM_POWER_DOMAINS-1:0] domain_ack,
    input  logic [2:0]                   rail_ready,
    output logic                         gate_bit_rate,
    output logic                         gate_symbol_rate,
    output logic                         gate_quarter_rate,
    output clk_status_t                  status
);

    localparam int IDLE_W = $clog2(IDLE_THRESHOLD + 1);

    logic [IDLE_W-1:0] idle_cnt;
    logic              clocks_gated;
    logic              gate_q;

    always_ff @(posedge ref_clk or negedge por_rst_n) begin
        if (!por_rst_n) begin
            idle_cnt     <= '0;
            clocks_gated <= 1'b0;
        end else if (protocol_active || phy_active) begin
            idle_cnt     <= '0;
            clocks_gated <= 1'b0;
        end else if (idle_cnt < IDLE_W'(IDLE_THRESHOLD)) begin
            idle_cnt <= idle_cnt + 1'b1;
        end else begin
            clocks_gated <= (power_mode != PM_FULL);  // Full power never gates
        end
    end

    always_ff @(posedge ref_clk or negedge por_rst_n) begin
        if (!por_rst_n) begin
            gate_q <= 1'b1;
            status <= '0;
        end else begin
            gate_q <= clocks_gated || !seq_active;
            status <= '{state:            state,
                        cfg:              active_cfg,
                        pll_locked_both:  pll_main_locked && pll_hs_locked,
                        settling:         settling,
                        clocks_gated:     clocks_gated,
                        thermal_throttle: thermal_throttle,
                        domains_acked:    &domain_ack,
                        rails_ready:      &rail_ready,
                        reserved:         1'b0};
        end
    end

    // All three high-speed domains share one gate decision
    assign gate_bit_rate     = gate_q;
    assign gate_symbol_rate  = gate_q;
    assign gate_quarter_rate = gate_q;

endmodule

/* hdl/clocking_ctrl_top.sv */
// Clocking controller top level
// Intake, power sequencer, voltage scaler and gate monitor

`timescale 1ns/1ns

module clocking_ctrl_top
    import clk_cfg_pkg::*;
    import clk_status_pkg::*;
#(
    parameter int NUM_POWER_DOMAINS   = 4,
    parameter int SETTLE_CYCLES       = 1000,
    parameter int LOCK_TIMEOUT_CYCLES = 100000,
    parameter int IDLE_THRESHOLD      = 100
) (
    input  logic                         ref_clk,
    input  logic                         por_rst_n,
    input  logic                         clocking_enable,
    input  logic                         thermal_throttle,
    input  logic                         cfg_valid,
    input  clk_cfg_t                     cfg,
    output logic                         cfg_ready,
    output logic [NUM_POWER_DOMAINS-1:0] domain_enable,
    output logic [NUM_POWER_DOMAINS-1:0] domain_isolate,
    input  logic [NUM_POWER_DOMAINS-1:0] domain_ack,
    input  logic [2:0]                   rail_ready,    // core, phy, pll regulators
    input  logic                         pll_main_locked,
    input  logic                         pll_hs_locked,
    output logic                         pll_enable,
    output logic [15:0]                  pll_hs_mult,
    output logic [31:0]                  pll_lock_cycles,
    input  logic                         protocol_active,
    input  logic                         phy_active,
    output logic                         gate_bit_rate,
    output logic                         gate_symbol_rate,
    output logic                         gate_quarter_rate,
    output logic                         all_clocks_stable,
    output vdd_mv_t                      vdd_core_mv,
    output vdd_mv_t                      vdd_phy_mv,
    output vdd_mv_t                      vdd_pll_mv,
    output clk_status_t                  status
);

    clk_cfg_t   active_cfg;
    seq_state_t seq_state;
    vdd_set_t   vdd;
    logic       seq_idle;
    logic       seq_active;
    logic       scale_start;
    logic       thermal_step;
    logic       settling;

    clk_cfg_intake u_intake (
        .ref_clk, .por_rst_n, .cfg_valid, .cfg, .cfg_ready, .seq_idle, .active_cfg
    );

    clk_power_sequencer #(
        .NUM_POWER_DOMAINS   (NUM_POWER_DOMAINS),
        .LOCK_TIMEOUT_CYCLES (LOCK_TIMEOUT_CYCLES)
    ) u_sequencer (
        .ref_clk, .por_rst_n, .clocking_enable, .thermal_throttle, .active_cfg,
        .domain_ack, .domain_enable, .domain_isolate, .rail_ready, .settling,
        .scale_start, .thermal_step, .pll_main_locked, .pll_hs_locked, .pll_enable,
        .pll_hs_mult, .pll_lock_cycles, .seq_idle, .seq_active,
        .state (seq_state),
        .all_clocks_stable
    );

    vdd_scaler #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_vdd_scaler (
        .ref_clk, .por_rst_n, .active_cfg, .scale_start, .thermal_step, .settling, .vdd
    );

    clk_gate_monitor #(
        .IDLE_THRESHOLD    (IDLE_THRESHOLD),
        .NUM_POWER_DOMAINS (NUM_POWER_DOMAINS)
    ) u_gate_monitor (
        .ref_clk, .por_rst_n, .protocol_active, .phy_active,
        .power_mode (active_cfg.power_mode),
        .seq_active,
        .state      (seq_state),
        .active_cfg, .pll_main_locked, .pll_hs_locked, .settling, .thermal_throttle,
        .domain_ack, .rail_ready, .gate_bit_rate, .gate_symbol_rate, .gate_quarter_rate,
        .status
    );

    assign vdd_core_mv = vdd.core;
    assign vdd_phy_mv  = vdd.phy;
    assign vdd_pll_mv  = vdd.pll;

endmodule

/* verif/tb_clocking_tasks.svh */
// Directed tests for the clocking controller
// Reference multiplier and rail tables, bounded waits and check helpers

`ifndef TB_CLOCKING_TASKS_SVH
`define TB_CLOCKING_TASKS_SVH

localparam int P_STABLE   = 0;
localparam int P_SETTLING = 1;
localparam int P_READY    = 2;
localparam int P_GATED    = 3;

function automatic clk_cfg_t make_cfg(input data_rate_t r, input signaling_mode_t s,
                                      input power_mode_t p);
    clk_cfg_t c;
    c.rate       = r;
    c.signaling  = s;
    c.power_mode = p;
    return c;
endfunction

function automatic vdd_set_t rails_mv(input int core, input int phy, input int pll);
    vdd_set_t v;
    v.core = vdd_mv_t'(core);
    v.phy  = vdd_mv_t'(phy);
    v.pll  = vdd_mv_t'(pll);
    return v;
endfunction

// Expected PLL multiplier per rate and signaling
function automatic logic [15:0] ref_mult(input data_rate_t r, input signaling_mode_t s);
    if (r == RATE_128G) begin
        return (s == SIG_PAM4) ? 16'd640 : 16'd1280;
    end
    return (r == RATE_64G) ? 16'd320 : 16'd160;
endfunction

// Expected core/phy/pll setpoints
function automatic vdd_set_t ref_vdd(input data_rate_t r, input power_mode_t p);
    if (r == RATE_128G && p == PM_FULL) return rails_mv(1000, 1200, 1300);
    if (r == RATE_128G && p == PM_LOW) return rails_mv(950, 1100, 1200);
    if (r == RATE_64G && p == PM_FULL) return rails_mv(950, 1100, 1200);
    if (r == RATE_32G && p == PM_FULL) return rails_mv(900, 1000, 1100);
    return rails_mv(850, 950, 1000);
endfunction

function automatic logic probe(input int which);
    case (which)
        P_STABLE:   return all_clocks_stable;
        P_SETTLING: return status.settling;
        P_READY:    return cfg_ready;
        default:    return status.clocks_gated;
    endcase
endfunction

task automatic next_cycle();
    @(posedge ref_clk);
    #1;  // Drive and sample away from the edge
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        error_count++;
    end
endtask

task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
        $display("Check failed: %s", what);
        error_count++;
    end
endtask

task automatic check_rails(input vdd_set_t exp);
    check_value("vdd_core_mv", vdd_core_mv, exp.core);
    check_value("vdd_phy_mv", vdd_phy_mv, exp.phy);
    check_value("vdd_pll_mv", vdd_pll_mv, exp.pll);
endtask

task automatic check_gates(input logic level);
    check_value("gate_bit_rate", gate_bit_rate, level);
    check_value("gate_symbol_rate", gate_symbol_rate, level);
    check_value("gate_quarter_rate", gate_quarter_rate, level);
endtask

task automatic wait_level(input int which, input logic level, input int limit,
                          input string what, output int cycles);
    cycles = 0;
    while (probe(which) !== level && cycles < limit) begin
        next_cycle();
        cycles++;
    end
    check_true(probe(which) === level, $sformatf("timed out waiting for %s", what));
endtask

task automatic wait_state(input seq_state_t want, input int limit, input string what,
                          output int cycles);
    cycles = 0;
    while (status.state !== want && cycles < limit) begin
        next_cycle();
        cycles++;
    end
    check_true(status.state === want, $sformatf("timed out waiting for %s", what));
endtask

// Holds the request until the intake takes it
task automatic send_cfg(input clk_cfg_t c, input int limit);
    int n;
    n = 0;
    cfg       = c;
    cfg_valid = 1'b1;
    while (!cfg_ready && n < limit) begin
        next_cycle();
        n++;
    end
    check_true(cfg_ready, "configuration request was never accepted");
    next_cycle();
    cfg_valid = 1'b0;
endtask

task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
        $display("Test %s: ok", name);
    end else begin
        fail_count++;
        $display("Test %s: %0d error(s)", name, error_count - errs_before);
    end
endtask

task automatic test_reset_bringup();
    int errs;
    int cycles;
    clk_status_t exp_status;
    errs = error_count;
    check_value("status.state", status.state, ST_RESET);
    check_value("pll_enable", pll_enable, 0);
    check_value("domain_enable", domain_enable, 0);
    check_value("domain_isolate", domain_isolate, {NUM_DOMAINS{1'b1}});
    check_value("all_clocks_stable", all_clocks_stable, 0);
    check_value("pll_lock_cycles", pll_lock_cycles, 0);
    check_rails(rails_mv(0, 0, 0));
    check_gates(1'b1);
    clocking_enable = 1'b1;
    wait_level(P_STABLE, 1'b1, 400, "all_clocks_stable after enable", cycles);
    next_cycle();  // Status word trails the sequencer by a cycle
    exp_status                 = '0;
    exp_status.state           = ST_ACTIVE;
    exp_status.cfg             = make_cfg(RATE_128G, SIG_PAM4, PM_FULL);
    exp_status.pll_locked_both = 1'b1;
    exp_status.domains_acked   = 1'b1;
    exp_status.rails_ready     = 1'b1;
    check_value("status", status, exp_status);
    check_value("pll_hs_mult", pll_hs_mult, ref_mult(RATE_128G, SIG_PAM4));
    // Lock timer starts one cycle after pll_enable rises
    check_value("pll_lock_cycles", pll_lock_cycles, LOCK_DELAY - 1);
    check_rails(ref_vdd(RATE_128G, PM_FULL));
    check_value("domain_isolate", domain_isolate, 0);
    report_test("reset and bring-up", errs);
endtask

task automatic test_cfg_handshake();
    int errs;
    int cycles;
    errs = error_count;
    send_cfg(make_cfg(RATE_64G, SIG_PAM4, PM_FULL), 20);
    send_cfg(make_cfg(RATE_64G, SIG_PAM4, PM_SLEEP), 20);
    wait_level(P_READY, 1'b0, 20, "sequencer leaving ST_ACTIVE on sleep", cycles);
    check_value("cfg_ready", cfg_ready, 0);
    // Stalled through the sleep bring-up, lands on its one ST_ACTIVE cycle
    send_cfg(make_cfg(RATE_64G, SIG_PAM4, PM_FULL), 400);
    wait_level(P_STABLE, 1'b1, 400, "all_clocks_stable after re-bring-up", cycles);
    check_value("pll_hs_mult", pll_hs_mult, ref_mult(RATE_64G, SIG_PAM4));
    check_rails(ref_vdd(RATE_64G, PM_FULL));
    report_test("configuration handshake", errs);
endtask

task automatic test_lock_timeout();
    int errs;
    int cycles;
    errs = error_count;
    withhold_lock   = 1'b1;
    clocking_enable = 1'b0;  // Park in ST_RESET after recovery
    send_cfg(make_cfg(RATE_64G, SIG_PAM4, PM_SLEEP), 20);
    wait_state(ST_LOCK_WAIT, 200, "ST_LOCK_WAIT without lock", cycles);
    wait_state(ST_RESET, LOCK_TIMEOUT_CYCLES + 20, "ST_RESET after lock timeout", cycles);
    check_true(cycles > LOCK_TIMEOUT_CYCLES, "lock timeout fired before its limit");
    next_cycle();
    check_value("pll_enable", pll_enable, 0);
    check_value("domain_enable", domain_enable, 0);
    check_value("domain_isolate", domain_isolate, {NUM_DOMAINS{1'b1}});
    report_test("lock timeout", errs);
endtask

task automatic test_thermal_limit();
    int errs;
    int cycles;
    vdd_set_t exp;
    errs = error_count;
    withhold_lock = 1'b0;
    exp = ref_vdd(RATE_128G, PM_FULL);
    send_cfg(make_cfg(RATE_128G, SIG_PAM4, PM_FULL), 20);
    clocking_enable = 1'b1;
    wait_level(P_STABLE, 1'b1, 400, "all_clocks_stable before throttle", cycles);
    thermal_throttle = 1'b1;
    wait_state(ST_THERMAL_LIMIT, 20, "ST_THERMAL_LIMIT", cycles);
    check_gates(1'b1);
    check_value("status.thermal_throttle", status.thermal_throttle, 1'b1);
    wait_level(P_SETTLING, 1'b1, 10, "settling after thermal step", cycles);
    wait_level(P_SETTLING, 1'b0, SETTLE_CYCLES + 10, "end of thermal settle", cycles);
    exp.core = exp.core - 12'd50;
    exp.phy  = exp.phy - 12'd50;
    exp.pll  = exp.pll - 12'd50;
    check_rails(exp);
    thermal_throttle = 1'b0;
    wait_level(P_STABLE, 1'b1, 20, "all_clocks_stable after throttle release", cycles);
    report_test("thermal limit", errs);
endtask

task automatic test_idle_gating();
    int errs;
    int cycles;
    bit gate_seen;
    errs = error_count;
    phy_active = 1'b1;
    send_cfg(make_cfg(RATE_128G, SIG_PAM4, PM_LOW), 20);
    wait_state(ST_POWER_SAVE, 20, "ST_POWER_SAVE", cycles);
    phy_active = 1'b0;
    wait_level(P_GATED, 1'b1, IDLE_THRESHOLD + 10, "clocks_gated in PM_LOW", cycles);
    check_true(cycles >= IDLE_THRESHOLD, "clocks gated before the idle threshold");
    check_gates(1'b1);
    phy_active = 1'b1;  // One-cycle activity pulse
    next_cycle();
    phy_active = 1'b0;
    next_cycle();
    check_value("status.clocks_gated", status.clocks_gated, 0);
    send_cfg(make_cfg(RATE_128G, SIG_PAM4, PM_FULL), 20);
    wait_state(ST_ACTIVE, 20, "ST_ACTIVE in PM_FULL", cycles);
    gate_seen = 1'b0;
    repeat (2 * IDLE_THRESHOLD) begin
        if (gate_bit_rate || gate_symbol_rate || gate_quarter_rate) gate_seen = 1'b1;
        next_cycle();
    end
    check_true(!gate_seen, "a clock gate rose in PM_FULL while active");
    report_test("idle gating", errs);
endtask

`endif

/* verif/tb_clocking_ctrl.sv */
// Testbench top for the clocking controller
// Clock, reset, DUT, domain/regulator/PLL responders and the test sequence

`timescale 1ns/1ns

module tb_clocking_ctrl
    import clk_cfg_pkg::*;
    import clk_status_pkg::*;
();

    localparam int NUM_DOMAINS         = 4;
    localparam int SETTLE_CYCLES       = 20;
    localparam int LOCK_TIMEOUT_CYCLES = 300;
    localparam int IDLE_THRESHOLD      = 16;
    localparam int ACK_DELAY           = 3;   // Domain and regulator response
    localparam int LOCK_DELAY          = 5;   // PLL lock after enable

    logic                   ref_clk = 1'b0;
    logic                   por_rst_n;
    logic                   clocking_enable;
    logic                   thermal_throttle;
    logic                   cfg_valid;
    clk_cfg_t               cfg;
    logic                   cfg_ready;
    logic [NUM_DOMAINS-1:0] domain_enable;
    logic [NUM_DOMAINS-1:0] domain_isolate;
    logic [NUM_DOMAINS-1:0] domain_ack;
    logic [2:0]             rail_ready;
    logic                   pll_main_locked;
    logic                   pll_hs_locked;
    logic                   pll_enable;
    logic [15:0]            pll_hs_mult;
    logic [31:0]            pll_lock_cycles;
    logic                   protocol_active;
    logic                   phy_active;
    logic                   gate_bit_rate;
    logic                   gate_symbol_rate;
    logic                   gate_quarter_rate;
    logic                   all_clocks_stable;
    vdd_mv_t                vdd_core_mv;
    vdd_mv_t                vdd_phy_mv;
    vdd_mv_t                vdd_pll_mv;
    clk_status_t            status;

    bit withhold_lock;  // Keeps both PLLs unlocked
    int ack_age;
    int lock_age;
    int error_count;
    int test_count;
    int fail_count;

    always #50 ref_clk = ~ref_clk;

    clocking_ctrl_top #(
        .NUM_POWER_DOMAINS   (NUM_DOMAINS),
        .SETTLE_CYCLES       (SETTLE_CYCLES),
        .LOCK_TIMEOUT_CYCLES (LOCK_TIMEOUT_CYCLES),
        .IDLE_THRESHOLD      (IDLE_THRESHOLD)
    ) u_clocking_ctrl_top (
        .ref_clk, .por_rst_n, .clocking_enable, .thermal_throttle, .cfg_valid, .cfg,
        .cfg_ready, .domain_enable, .domain_isolate, .domain_ack, .rail_ready,
        .pll_main_locked, .pll_hs_locked, .pll_enable, .pll_hs_mult, .pll_lock_cycles,
        .protocol_active, .phy_active, .gate_bit_rate, .gate_symbol_rate,
        .gate_quarter_rate, .all_clocks_stable, .vdd_core_mv, .vdd_phy_mv, .vdd_pll_mv,
        .status
    );

    `include "tb_clocking_tasks.svh"

    // Power domains, regulators and PLLs answer a fixed time after enable
    initial begin
        domain_ack      = '0;
        rail_ready      = '0;
        pll_main_locked = 1'b0;
        pll_hs_locked   = 1'b0;
        ack_age         = 0;
        lock_age        = 0;
        forever begin
            @(posedge ref_clk);
            #1;
            ack_age         = (domain_enable == '1) ? ack_age + 1 : 0;
            lock_age        = (pll_enable && !withhold_lock) ? lock_age + 1 : 0;
            domain_ack      = {NUM_DOMAINS{ack_age >= ACK_DELAY}};
            rail_ready      = {3{ack_age >= ACK_DELAY}};
            pll_main_locked = (lock_age >= LOCK_DELAY);
            pll_hs_locked   = (lock_age >= LOCK_DELAY);
        end
    end

    initial begin
        por_rst_n        = 1'b0;
        clocking_enable  = 1'b0;
        thermal_throttle = 1'b0;
        cfg_valid        = 1'b0;
        cfg              = make_cfg(RATE_128G, SIG_PAM4, PM_FULL);
        protocol_active  = 1'b0;
        phy_active       = 1'b0;
        withhold_lock    = 1'b0;
        error_count      = 0;
        test_count       = 0;
        fail_count       = 0;
        repeat (10) @(posedge ref_clk);
        #1;
        por_rst_n = 1'b1;

        test_reset_bringup();
        test_cfg_handshake();
        test_lock_timeout();
        test_thermal_limit();
        test_idle_gating();

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 test_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* clocking_ctrl.f */
+incdir+verif
hdl/clk_cfg_pkg.sv
hdl/clk_status_pkg.sv
hdl/clk_cfg_intake.sv
hdl/clk_power_sequencer.sv
hdl/vdd_scaler.sv
hdl/clk_gate_monitor.sv
hdl/clocking_ctrl_top.sv
verif/tb_clocking_ctrl.sv
